//--- Makefile
# Verilator build and run of the execCore testbench
# Override any variable on the command line, e.g. make run LOG=other.log

VERILATOR ?= verilator
TOP       ?= execCoreTb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

SRCS := $(filter %.sv %.v,$(shell cat $(FLIST)))
HDRS := $(wildcard verilog/*.svh)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# Rebuilt only when a source, header or the file list changes
$(BIN): $(SRCS) $(HDRS) $(FLIST)
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

# Verdict comes from the log, not the exit code of the simulator
run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -q "Result: PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- flist.f
+incdir+verilog
verilog/regTypesPkg.sv
verilog/aluOpsPkg.sv
verilog/dualPortRam.sv
verilog/registerFile.sv
verilog/operandForward.sv
verilog/aluUnit.sv
verilog/execCore.sv
tb/execCoreTb.sv

//--- tb/execCoreTb.sv
// Directed testbench for execCore that checks every writeback against a shadow register model
// Run from the project root through the Makefile; the last lines give the counts and verdict
`timescale 1ns/1ps
`default_nettype none

`include "regFile_cfg.svh"

module execCoreTb
	import regTypesPkg::*;
	import aluOpsPkg::*;
();

	localparam int clkPeriod = 20;
	localparam int numInit = 31;   // r1..r31
	localparam int aluReps = 12;   // Per operation
	localparam int numZero = 6;
	localparam int chainLen = 8;   // Per chain mode
	localparam int distReps = 6;
	localparam int streamLen = 150;
	localparam int totalInstr = numInit + 8 * aluReps + numZero + 3 * chainLen + 1
		+ 4 * distReps + streamLen;
	localparam int watchdogCycles = 2 * totalInstr + 200; // Idle and reset slack

	logic     iClk = 1'b0;
	logic     rstN;
	logic     iValid;
	aluOp_t   iOp;
	regAddr_t iRd;
	regAddr_t iRs1;
	regAddr_t iRs2;
	logic     iUseImm;
	imm_t     iImm;
	logic     oResValid;
	regAddr_t oResRd;
	regData_t oResData;

	regData_t    shadow [32];      // Architectural state as the model sees it
	regAddr_t    expRd [$];        // Expected writebacks in issue order
	regData_t    expData [$];
	int          expCycle [$];     // Negedge count when each one is due
	int          cycleCount = 0;
	int          valueErrors = 0;
	int          protocolErrors = 0;
	int          checkedCount = 0;
	string       testName = "reset";
	logic [31:0] rngState = 32'h926057ef;

	execCore dut0 (
		.iClk      (iClk),
		.rstN      (rstN),
		.iValid    (iValid),
		.iOp       (iOp),
		.iRd       (iRd),
		.iRs1      (iRs1),
		.iRs2      (iRs2),
		.iUseImm   (iUseImm),
		.iImm      (iImm),
		.oResValid (oResValid),
		.oResRd    (oResRd),
		.oResData  (oResData)
	);

	always #(clkPeriod / 2) iClk = ~iClk;

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [31:0] randWord();
		rngState = xorshift32(rngState);
		return rngState;
	endfunction

	function automatic regAddr_t randReg();
		logic [31:0] r;
		r = randWord();
		return r[`RF_ADDR_WIDTH-1:0];
	endfunction

	function automatic imm_t randImm();
		logic [31:0] r;
		r = randWord();
		return r[`RF_IMM_WIDTH-1:0];
	endfunction

	function automatic aluOp_t randOp();
		logic [31:0] r;
		r = randWord();
		return aluOp_t'(r[2:0]);
	endfunction

	// Reference ALU built from the operation rules
	function automatic regData_t expectedResult(input aluOp_t op, input regData_t a,
		input regData_t b);
		case (op)
			aluAdd:  return a + b;
			aluSub:  return a - b;
			aluAnd:  return a & b;
			aluOr:   return a | b;
			aluXor:  return a ^ b;
			aluSlt:  return (a[`RF_DATA_WIDTH-1] != b[`RF_DATA_WIDTH-1]) ?
				regData_t'(a[`RF_DATA_WIDTH-1]) : regData_t'(a < b); // Sign bits decide first
			aluSll:  return a << (b % 32); // Amount modulo 32
			aluSrl:  return a >> (b % 32);
			default: return '0;
		endcase
	endfunction

	task automatic checkEq(input string what, input regData_t expected, input regData_t actual);
		if (actual !== expected) begin
			valueErrors++;
			$display("error %s: %s expected %h, actual %h", testName, what, expected, actual);
		end
	endtask

	// Updates the model before the drive edge so the shadow follows issue order
	task automatic issue(input aluOp_t op, input regAddr_t rd, input regAddr_t rs1,
		input regAddr_t rs2, input logic useImm, input imm_t imm);
		regData_t a;
		regData_t b;
		regData_t res;
		a = shadow[rs1];
		b = useImm ? {{(`RF_DATA_WIDTH - `RF_IMM_WIDTH){imm[`RF_IMM_WIDTH-1]}}, imm}
			: shadow[rs2];
		res = expectedResult(op, a, b);
		if (rd != '0) shadow[rd] = res; // r0 keeps zero
		@(posedge iClk);
		expRd.push_back(rd);
		expData.push_back(res);
		expCycle.push_back(cycleCount + 3); // Two negedges after the issue negedge
		iValid  <= 1'b1;
		iOp     <= op;
		iRd     <= rd;
		iRs1    <= rs1;
		iRs2    <= rs2;
		iUseImm <= useImm;
		iImm    <= imm;
	endtask

	task automatic idle();
		@(posedge iClk);
		iValid <= 1'b0;
	endtask

	task automatic drainResults();
		idle();
		while (expRd.size() != 0) @(negedge iClk);
		repeat (3) @(negedge iClk); // Catch any stray strobe
	endtask

	// Writeback monitor sampling mid-cycle
	always @(negedge iClk) begin
		cycleCount++;
		if (!rstN) begin
			if (oResValid === 1'b1) begin
				protocolErrors++;
				$display("Writeback strobe seen while reset is asserted");
			end
			checkEq("rd", '0, regData_t'(oResRd)); // Output registers held at zero
			checkEq("data", '0, oResData);
		end else begin
			if (expCycle.size() != 0 && expCycle[0] < cycleCount) begin
				protocolErrors++;
				$display("No writeback for r%0d in %s by cycle %0d", expRd[0], testName,
					expCycle[0]);
				void'(expRd.pop_front());
				void'(expData.pop_front());
				void'(expCycle.pop_front());
			end
			if (oResValid !== 1'b0) begin
				if (expRd.size() == 0) begin
					protocolErrors++;
					$display("Unexpected writeback to r%0d in %s", oResRd, testName);
				end else begin
					if (expCycle[0] != cycleCount) begin
						protocolErrors++;
						$display("Writeback in %s at cycle %0d, due at %0d", testName,
							cycleCount, expCycle[0]);
					end
					checkEq("rd", regData_t'(expRd[0]), regData_t'(oResRd));
					checkEq("data", expData[0], oResData);
					checkedCount++;
					void'(expRd.pop_front());
					void'(expData.pop_front());
					void'(expCycle.pop_front());
				end
			end
		end
	end

	// Fill every register through r0 plus an immediate
	task automatic initRegisters();
		testName = "init";
		for (int r = 1; r < 32; r++) issue(aluAdd, regAddr_t'(r), '0, '0, 1'b1, randImm());
		drainResults();
	endtask

	task automatic aluOperations();
		testName = "aluOps";
		for (int op = 0; op < 8; op++) begin
			for (int n = 0; n < aluReps; n++) begin
				issue(aluOp_t'(op[2:0]), randReg(), randReg(), randReg(), randWord() > 32'h80000000,
					randImm());
			end
		end
		drainResults();
	endtask

	task automatic registerZero();
		testName = "regZero";
		issue(aluAdd, 5'd0, 5'd5, 5'd0, 1'b1, 16'h7abc); // Reported but not stored
		issue(aluOr, 5'd7, 5'd0, 5'd0, 1'b0, '0);        // Distance 1 from r0 write
		issue(aluAdd, 5'd8, 5'd0, 5'd0, 1'b1, 16'h0042);
		issue(aluAdd, 5'd0, 5'd8, 5'd8, 1'b0, '0);       // Nonzero r0 write before a B read
		issue(aluSub, 5'd9, 5'd3, 5'd0, 1'b0, '0);
		idle();
		idle();
		issue(aluOr, 5'd10, 5'd0, 5'd0, 1'b0, '0);
		drainResults();
	endtask

	// Each link reads the previous destination on A, B, then both
	task automatic backToBackChains();
		regAddr_t prev;
		regAddr_t rd;
		testName = "chain";
		prev = 5'd10;
		issue(aluAdd, prev, 5'd1, 5'd0, 1'b1, randImm());
		for (int mode = 0; mode < 3; mode++) begin
			for (int i = 0; i < chainLen; i++) begin
				rd = regAddr_t'(8 + i + 8 * mode); // r8..r31, never r0
				if (mode == 0) issue(randOp(), rd, prev, randReg(), 1'b0, '0);
				else if (mode == 1) issue(randOp(), rd, randReg(), prev, 1'b0, '0);
				else issue(aluAdd, rd, prev, prev, 1'b0, '0);
				prev = rd;
			end
		end
		drainResults();
	endtask

	// One filler between producer and consumer hits the register file bypass
	task automatic distanceTwo();
		testName = "distTwo";
		for (int i = 0; i < distReps; i++) begin
			issue(aluAdd, 5'd20, 5'd1, 5'd0, 1'b1, randImm());
			issue(aluOr, 5'd21, 5'd2, 5'd3, 1'b0, '0);
			if (i % 3 == 0) issue(aluSub, 5'd22, 5'd20, 5'd4, 1'b0, '0);
			else if (i % 3 == 1) issue(aluXor, 5'd22, 5'd4, 5'd20, 1'b0, '0);
			else issue(aluAdd, 5'd22, 5'd20, 5'd20, 1'b0, '0);
			issue(aluAnd, 5'd23, 5'd5, 5'd5, 1'b0, '0); // Same source on both ports
		end
		drainResults();
	endtask

	task automatic randomStream();
		testName = "stream";
		for (int i = 0; i < streamLen; i++) begin
			issue(randOp(), randReg(), randReg(), randReg(), randWord() > 32'h80000000, randImm());
		end
		drainResults();
	endtask

	initial begin
		foreach (shadow[r]) shadow[r] = '0;
		rstN    <= 1'b0;
		iValid  <= 1'b0;
		iOp     <= aluAdd;
		iRd     <= '0;
		iRs1    <= '0;
		iRs2    <= '0;
		iUseImm <= 1'b0;
		iImm    <= '0;
		repeat (5) @(posedge iClk);
		rstN <= 1'b1;
		repeat (4) @(posedge iClk); // Output must stay quiet before the first issue
		initRegisters();
		aluOperations();
		registerZero();
		backToBackChains();
		distanceTwo();
		randomStream();
		$display("Summary: %0d value errors, %0d protocol errors, %0d results checked",
			valueErrors, protocolErrors, checkedCount);
		if (valueErrors == 0 && protocolErrors == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

	// Watchdog
	initial begin
		#(clkPeriod * watchdogCycles);
		$display("Timeout after %0d cycles, the tests did not finish", watchdogCycles);
		$display("Result: FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog/aluOpsPkg.sv
// ALU operation encoding and shift-amount type for the execute stage
// Import with aluOpsPkg::* where an opcode or shift amount is handled
`default_nettype none

`include "regFile_cfg.svh"

package aluOpsPkg;

	// 3-bit opcode, one per ALU function
	typedef enum logic [2:0] {
		aluAdd = 3'd0, // a + b, wraps
		aluSub = 3'd1, // a - b, wraps
		aluAnd = 3'd2,
		aluOr  = 3'd3,
		aluXor = 3'd4,
		aluSlt = 3'd5, // Signed a < b gives 1
		aluSll = 3'd6, // a << b[4:0]
		aluSrl = 3'd7  // a >> b[4:0], zero fill
	} aluOp_t;

	typedef logic [$clog2(`RF_DATA_WIDTH)-1:0] shamt_t; // Low bits of operand B

endpackage

`default_nettype wire

//--- verilog/aluUnit.sv
// Execute stage, computes the selected operation and registers the result
// Output lands one cycle after the operands, with its destination and valid
`timescale 1ns/1ps
`default_nettype none

`include "regFile_cfg.svh"

module aluUnit
	import regTypesPkg::*;
	import aluOpsPkg::*;
(
	input wire logic     iClk,
	input wire logic     rstN,

	// Stage-1 instruction
	input wire logic     iValid,
	input wire aluOp_t   iOp,
	input wire regAddr_t iRd,
	input wire regData_t iOpA,
	input wire regData_t iOpB,

	// Stage-2 result
	output logic         oValid,
	output regAddr_t     oRd,
	output regData_t     oResult
);

	shamt_t   shamt;     // Shift count, B modulo 32
	logic     lessThan;  // Signed compare for slt
	regData_t aluResult; // Next result

	assign shamt    = iOpB[$bits(shamt_t)-1:0];
	assign lessThan = $signed(iOpA) < $signed(iOpB);

	always_comb begin
		case (iOp)
			aluAdd:  aluResult = iOpA + iOpB; // Carry out dropped
			aluSub:  aluResult = iOpA - iOpB;
			aluAnd:  aluResult = iOpA & iOpB;
			aluOr:   aluResult = iOpA | iOpB;
			aluXor:  aluResult = iOpA ^ iOpB;
			aluSlt:  aluResult = {{(`RF_DATA_WIDTH-1){1'b0}}, lessThan};
			aluSll:  aluResult = iOpA << shamt;
			aluSrl:  aluResult = iOpA >> shamt; // Logical, zero fill
			default: aluResult = '0;
		endcase
	end

	// Result register, cleared on reset
	always_ff @(posedge iClk or negedge rstN) begin
		if (!rstN) begin
			oValid  <= 1'b0;
			oRd     <= '0;
			oResult <= '0;
		end else begin
			oValid  <= iValid;
			oRd     <= iRd;
			oResult <= aluResult;
		end
	end

endmodule

`default_nettype wire

//--- verilog/dualPortRam.sv
// Generic memory, one write port and one registered read port on the same clock
// Used as a bank of the register file, contents come up undefined
`timescale 1ns/1ps
`default_nettype none

module dualPortRam #(
	parameter int DATA_WIDTH = 32,
	parameter int ADDR_WIDTH = 5
) (
	input wire logic iClk,

	// Port A, write only
	input wire logic                  iWeA,   // Write strobe
	input wire logic [ADDR_WIDTH-1:0] iAddrA,
	input wire logic [DATA_WIDTH-1:0] iDataA,

	// Port B, read only
	input wire logic [ADDR_WIDTH-1:0] iAddrB,
	output logic     [DATA_WIDTH-1:0] oDataB  // Valid one cycle after iAddrB
);

	// Storage, one word per address
	logic [DATA_WIDTH-1:0] mem [2**ADDR_WIDTH];

	// Write commits at the edge
	always_ff @(posedge iClk) begin
		if (iWeA) begin
			mem[iAddrA] <= iDataA;
		end
	end

	// Registered read
	// Same-address write in this cycle returns the old word,
	// the register file covers that case itself
	always_ff @(posedge iClk) begin
		oDataB <= mem[iAddrB];
	end

endmodule

`default_nettype wire

//--- verilog/execCore.sv
// Three-stage integer execute core, issue, operands and ALU, then writeback
// One instruction per cycle, result on oResValid two cycles after issue
`timescale 1ns/1ps
`default_nettype none

`include "regFile_cfg.svh"

module execCore
	import regTypesPkg::*;
	import aluOpsPkg::*;
(
	input wire logic     iClk,
	input wire logic     rstN,

	// Issue, fields valid with iValid
	input wire logic     iValid,
	input wire aluOp_t   iOp,
	input wire regAddr_t iRd,
	input wire regAddr_t iRs1,
	input wire regAddr_t iRs2,
	input wire logic     iUseImm,
	input wire imm_t     iImm,

	// Writeback, one cycle strobe
	output logic         oResValid,
	output regAddr_t     oResRd,
	output regData_t     oResData
);

	// Stage-1 fields
	logic     s1Valid;
	aluOp_t   s1Op;
	regAddr_t s1Rd;
	regAddr_t s1Rs1;     // Kept for the forwarding compare
	regAddr_t s1Rs2;
	logic     s1UseImm;
	imm_t     s1Imm;

	regData_t rfData1;   // Register file read data, stage 1
	regData_t rfData2;
	regData_t opA;       // Selected ALU operands
	regData_t opB;

	// Stage-2 result from the ALU
	logic     aluValid;
	regAddr_t aluRd;
	regData_t aluResult;

	// Stage 0 to stage 1, the register file reads in parallel
	always_ff @(posedge iClk or negedge rstN) begin
		if (!rstN) begin
			s1Valid  <= 1'b0;
			s1Op     <= aluAdd;
			s1Rd     <= {`RF_ADDR_WIDTH{1'b0}};
			s1Rs1    <= {`RF_ADDR_WIDTH{1'b0}};
			s1Rs2    <= {`RF_ADDR_WIDTH{1'b0}};
			s1UseImm <= 1'b0;
		end else begin
			s1Valid  <= iValid;
			s1Op     <= iOp;
			s1Rd     <= iRd;
			s1Rs1    <= iRs1;
			s1Rs2    <= iRs2;
			s1UseImm <= iUseImm;
		end
	end

	// Immediate is payload only
	always_ff @(posedge iClk) begin
		s1Imm <= iImm;
	end

	// Read at issue, write from stage 2
	registerFile rf0 (
		.iClk       (iClk),
		.rstN       (rstN),
		.iAddrRead0 (iRs1),
		.iAddrRead1 (iRs2),
		.oDataRead0 (rfData1),
		.oDataRead1 (rfData2),
		.iEnWrite   (aluValid),
		.iAddrWrite (aluRd),
		.iDataWrite (aluResult)
	);

	// Distance-one hazards resolved here
	operandForward fwd0 (
		.iRs1      (s1Rs1),
		.iRs2      (s1Rs2),
		.iRfData1  (rfData1),
		.iRfData2  (rfData2),
		.iUseImm   (s1UseImm),
		.iImm      (s1Imm),
		.iFwdValid (aluValid),
		.iFwdRd    (aluRd),
		.iFwdData  (aluResult),
		.oOpA      (opA),
		.oOpB      (opB)
	);

	aluUnit alu0 (
		.iClk    (iClk),
		.rstN    (rstN),
		.iValid  (s1Valid),
		.iOp     (s1Op),
		.iRd     (s1Rd),
		.iOpA    (opA),
		.iOpB    (opB),
		.oValid  (aluValid),
		.oRd     (aluRd),
		.oResult (aluResult)
	);

	// Writeback, r0 writes still reported here
	assign oResValid = aluValid;
	assign oResRd    = aluRd;
	assign oResData  = aluResult;

endmodule

`default_nettype wire

//--- verilog/operandForward.sv
// Operand select for the ALU, register data, forwarded result or immediate
// Purely combinational, sits in stage 1 between the register file and aluUnit
`timescale 1ns/1ps
`default_nettype none

`include "regFile_cfg.svh"

module operandForward
	import regTypesPkg::*;
(
	// Stage-1 source registers and their register file data
	input wire regAddr_t iRs1,
	input wire regAddr_t iRs2,
	input wire regData_t iRfData1,
	input wire regData_t iRfData2,

	input wire logic     iUseImm, // Immediate replaces source 2
	input wire imm_t     iImm,

	// Result now in stage 2
	input wire logic     iFwdValid,
	input wire regAddr_t iFwdRd,
	input wire regData_t iFwdData,

	output regData_t     oOpA,
	output regData_t     oOpB
);

	logic     fwdA;   // Stage-2 result replaces source 1
	logic     fwdB;   // Stage-2 result replaces source 2
	regData_t immExt; // Sign-extended immediate

	// Never forward into r0, it stays zero
	assign fwdA = iFwdValid && (iFwdRd != '0) && (iFwdRd == iRs1);
	assign fwdB = iFwdValid && (iFwdRd != '0) && (iFwdRd == iRs2);

	assign immExt = {{(`RF_DATA_WIDTH - `RF_IMM_WIDTH){iImm[`RF_IMM_WIDTH-1]}}, iImm};

	// A is always a register
	assign oOpA = fwdA ? iFwdData : iRfData1;

	// Immediate wins over any forward on B
	assign oOpB = iUseImm ? immExt :
		fwdB ? iFwdData : iRfData2;

endmodule

`default_nettype wire

//--- verilog/regFile_cfg.svh
// Width settings shared by the register file and the execute datapath
// Pull in with `include wherever a register field is sized
`ifndef REGFILE_CFG_SVH
`define REGFILE_CFG_SVH

// Register and datapath width
`define RF_DATA_WIDTH 32

// Register number width, 2**5 = 32 registers
`define RF_ADDR_WIDTH 5

// Raw immediate field, sign-extended to RF_DATA_WIDTH before the ALU
`define RF_IMM_WIDTH 16

`endif

//--- verilog/regTypesPkg.sv
// Plain-vector types for register values, register numbers and immediates
// Import with regTypesPkg::* in the module header
`default_nettype none

`include "regFile_cfg.svh"

package regTypesPkg;

	// Register contents or ALU operand
	typedef logic [`RF_DATA_WIDTH-1:0] regData_t;

	// Register number, r0 is hardwired to zero
	typedef logic [`RF_ADDR_WIDTH-1:0] regAddr_t;

	typedef logic [`RF_IMM_WIDTH-1:0] imm_t; // Immediate as it arrives, not extended

endpackage

`default_nettype wire

//--- verilog/registerFile.sv
// 32x32 register file, two reads and one write per cycle, r0 reads as zero
// Reads return data one cycle after the address, write-to-read bypass included
`timescale 1ns/1ps
`default_nettype none

`include "regFile_cfg.svh"

module registerFile
	import regTypesPkg::*;
(
	input wire logic iClk,
	input wire logic rstN,

	// Read ports, one cycle latency
	input wire regAddr_t iAddrRead0,
	input wire regAddr_t iAddrRead1,
	output regData_t     oDataRead0,
	output regData_t     oDataRead1,

	// Write port, commits at the edge
	input wire logic     iEnWrite,
	input wire regAddr_t iAddrWrite,
	input wire regData_t iDataWrite
);

	regAddr_t addrRead [2];    // Read addresses by port
	regData_t ramData [2];     // Raw bank outputs
	regAddr_t addrReadQ [2];   // Address of the word now on the bank output
	logic     bypassQ [2];     // Read collided with a write last cycle
	regData_t bypassDataQ [2]; // Write data captured for the collision
	logic     weBank;          // Write strobe seen by both banks

	assign addrRead[0] = iAddrRead0;
	assign addrRead[1] = iAddrRead1;

	// r0 is never stored
	assign weBank = iEnWrite && (iAddrWrite != '0);

	// Two copies, every write goes to both, each serves one read port
	dualPortRam #(
		.DATA_WIDTH (`RF_DATA_WIDTH),
		.ADDR_WIDTH (`RF_ADDR_WIDTH)
	) bank0 (
		.iClk   (iClk),
		.iWeA   (weBank),
		.iAddrA (iAddrWrite),
		.iDataA (iDataWrite),
		.iAddrB (addrRead[0]),
		.oDataB (ramData[0])
	);

	dualPortRam #(
		.DATA_WIDTH (`RF_DATA_WIDTH),
		.ADDR_WIDTH (`RF_ADDR_WIDTH)
	) bank1 (
		.iClk   (iClk),
		.iWeA   (weBank),
		.iAddrA (iAddrWrite),
		.iDataA (iDataWrite),
		.iAddrB (addrRead[1]),
		.oDataB (ramData[1])
	);

	// Track each read alongside the bank pipeline
	always_ff @(posedge iClk or negedge rstN) begin
		if (!rstN) begin
			for (int p = 0; p < 2; p++) begin
				addrReadQ[p]   <= '0;
				bypassQ[p]     <= 1'b0;
				bypassDataQ[p] <= '0;
			end
		end else begin
			for (int p = 0; p < 2; p++) begin
				addrReadQ[p]   <= addrRead[p];
				bypassQ[p]     <= weBank && (addrRead[p] == iAddrWrite); // weBank drops r0
				bypassDataQ[p] <= iDataWrite;
			end
		end
	end

	// Zero register first, then the fresh write, then the bank
	assign oDataRead0 = (addrReadQ[0] == '0) ? '0 :
		bypassQ[0] ? bypassDataQ[0] : ramData[0];
	assign oDataRead1 = (addrReadQ[1] == '0) ? '0 :
		bypassQ[1] ? bypassDataQ[1] : ramData[1];

endmodule

`default_nettype wire
